//--- build.f
common/bridge_pkg.sv
verilog/msg_fifo.sv
cmd_engine/cmd_engine.sv
verilog/stream_status.sv
verilog/host_bridge_top.sv
test/host_bridge_assert.sv
test/tb_host_bridge.sv

//--- test/tb_host_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_host_bridge;

  import bridge_pkg::*;

  localparam int SEED      = 52581;
  localparam int MEM_DW    = 64;
  localparam int BEATS     = MEM_DW / MSG_WIDTH;
  localparam int DEPTH     = 16;
  localparam int HB_CYCLES = 64;
  localparam int N_ADDR    = 4;
  localparam int N_BURST   = 24;
  localparam int N_MIX     = 20;

  logic                  clk;
  logic                  rst_n;
  logic                  wr_en;
  msg_t                  wr_data;
  logic                  wr_full;
  logic                  host_wr_open;
  logic                  reply_rden;
  msg_t                  reply_data;
  logic                  reply_empty;
  logic                  reply_eof;
  logic                  loop_rden;
  msg_t                  loop_data;
  logic                  loop_empty;
  logic                  loop_eof;
  logic                  mem_valid;
  mem_req_t              mem_req;
  logic                  mem_ready;
  logic                  mem_rd_valid;
  logic [MEM_DW-1:0]     mem_rd_data;
  logic                  led_heartbeat;
  logic                  led_error;
  logic                  led_done;

  msg_t                  msgs[$];
  msg_t                  exp_loop[$];
  msg_t                  exp_reply[$];
  logic [MEM_DW-1:0]     mem [logic [ADDR_WIDTH-1:0]];
  logic [ADDR_WIDTH-1:0] addr_set [N_ADDR];
  int                    exp_reqs;
  int                    req_count = 0;
  int                    loop_idx = 0;
  int                    rep_idx = 0;
  int                    cycle = 0;
  int                    limit = 0;
  int                    last_hb;
  int                    hb_toggles = 0;
  logic                  hb_prev;
  logic                  saw_full = 1'b0;
  logic                  reply_go = 1'b0;
  int                    errs [6] = '{default: 0};
  string                 names [6] = '{"loopback", "write_read", "backpressure",
                                       "illegal_op", "end_of_stream", "heartbeat"};

  host_bridge_top #(
    .MEM_DATA_WIDTH(MEM_DW), .FIFO_DEPTH(DEPTH), .HEARTBEAT_CYCLES(HB_CYCLES)
  ) host_bridge_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Unwritten memory words, built from the whole address
  function automatic logic [MEM_DW-1:0] fill_pattern(input logic [ADDR_WIDTH-1:0] a);
    return {5'd0, a, 5'h15, ~a};
  endfunction

  task automatic check_equal(input int test, input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errs[test]++;
    end
  endtask

  task automatic add_op(input logic is_wr, input logic [ADDR_WIDTH-1:0] a);
    int b;
    msgs.push_back({is_wr ? op_write : op_read, 1'b0, a});
    for (b = 0; is_wr && b < BEATS; b++) begin
      msgs.push_back($urandom());
    end
  endtask

  // ****************************************
  // Stimulus and reference model
  // ****************************************
  task automatic build_stream();
    int i;
    int ill_pos;
    for (i = 0; i < N_ADDR; i++) begin
      addr_set[i] = ADDR_WIDTH'({$urandom_range(0, 32'hfffff), 2'(i)});
      add_op(1'b1, addr_set[i]);
    end
    // Read burst fills the reply queue while the host holds off
    for (i = 0; i < N_BURST; i++) begin
      add_op(1'b0, addr_set[$urandom_range(0, N_ADDR-1)]);
    end
    ill_pos = $urandom_range(0, N_MIX-1);
    for (i = 0; i < N_MIX; i++) begin
      if (i == ill_pos) begin
        msgs.push_back(32'h3000_0000 | i);
      end
      add_op(1'($urandom_range(0, 1)), addr_set[$urandom_range(0, N_ADDR-1)]);
    end
    msgs.push_back('1);
    // Must stay queued behind the end word
    add_op(1'b1, addr_set[0]);
    add_op(1'b0, addr_set[0]);
  endtask

  function automatic void ref_replies();
    logic [MEM_DW-1:0]     shadow [logic [ADDR_WIDTH-1:0]];
    logic [MEM_DW-1:0]     d;
    logic [ADDR_WIDTH-1:0] a;
    int                    i;
    int                    b;
    i = 0;
    exp_reqs = 0;
    while (i < msgs.size() && msgs[i] != '1) begin
      a = msgs[i][ADDR_WIDTH-1:0];
      if (msgs[i][MSG_WIDTH-1 -: OP_WIDTH] == op_write) begin
        for (b = 0; b < BEATS; b++) begin
          d[b*MSG_WIDTH +: MSG_WIDTH] = msgs[i+1+b];
        end
        shadow[a] = d;
        exp_reqs++;
        i += 1 + BEATS;
      end else if (msgs[i][MSG_WIDTH-1 -: OP_WIDTH] == op_read) begin
        d = shadow.exists(a) ? shadow[a] : fill_pattern(a);
        // Low word first
        for (b = 0; b < BEATS; b++) begin
          exp_reply.push_back(d[b*MSG_WIDTH +: MSG_WIDTH]);
        end
        exp_reqs++;
        i++;
      end else begin
        i++;
      end
    end
    // Loopback carries everything up to and including the end word
    for (b = 0; b <= i && b < msgs.size(); b++) begin
      exp_loop.push_back(msgs[b]);
    end
  endfunction

  // ****************************************
  // Memory model and host readers
  // ****************************************
  initial begin : mem_model
    int                    delay;
    logic [ADDR_WIDTH-1:0] a;
    mem_ready    <= 1'b0;
    mem_rd_valid <= 1'b0;
    mem_rd_data  <= '0;
    forever begin
      @(posedge clk);
      mem_rd_valid <= 1'b0;
      if (mem_valid && mem_ready) begin
        req_count++;
        a = mem_req.addr;
        if (!mem_req.is_read) begin
          mem[a] = mem_req.wdata[MEM_DW-1:0];
        end else begin
          delay = $urandom_range(0, 3);
          repeat (delay) @(posedge clk);
          mem_rd_valid <= 1'b1;
          mem_rd_data  <= mem.exists(a) ? mem[a] : fill_pattern(a);
        end
      end
      mem_ready <= ($urandom_range(0, 3) != 0);
    end
  end

  initial begin : loop_reader
    loop_rden <= 1'b0;
    forever begin
      @(posedge clk);
      if (loop_rden && !loop_empty) begin
        check_equal(0, loop_idx < exp_loop.size(), 1'b1, "loopback word within stream");
        if (loop_idx < exp_loop.size()) begin
          check_equal(0, loop_data, exp_loop[loop_idx], "loopback word");
        end
        loop_idx++;
      end
      loop_rden <= rst_n && ($urandom_range(0, 2) != 0);
    end
  end

  initial begin : reply_reader
    reply_rden <= 1'b0;
    forever begin
      @(posedge clk);
      if (reply_rden && !reply_empty) begin
        check_equal(1, rep_idx < exp_reply.size(), 1'b1, "reply word within stream");
        if (rep_idx < exp_reply.size()) begin
          check_equal(1, reply_data, exp_reply[rep_idx], "reply word");
        end
        rep_idx++;
      end
      reply_rden <= reply_go && ($urandom_range(0, 3) != 0);
    end
  end

  // Cycle count and heartbeat period
  always @(posedge clk) begin
    cycle++;
    if (!rst_n) begin
      last_hb = cycle + 1;
      hb_prev = 1'b0;
    end else if (led_heartbeat !== hb_prev) begin
      check_equal(5, cycle - last_hb, HB_CYCLES, "heartbeat half period");
      last_hb = cycle;
      hb_prev = led_heartbeat;
      hb_toggles++;
    end
  end

  initial begin : watchdog
    @(posedge clk);
    while (cycle < limit) begin
      @(posedge clk);
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("sim failed");
    $finish;
  end

  // ****************************************
  // Host writer and final checks
  // ****************************************
  initial begin : main
    int idx;
    int hold_idx;
    int t;
    int total;
    rst_n        <= 1'b0;
    wr_en        <= 1'b0;
    wr_data      <= '0;
    host_wr_open <= 1'b1;
    void'($urandom(SEED));
    build_stream();
    ref_replies();
    limit = 200 * msgs.size() + 1000;
    // Inbound full this late means the reply queue is full as well
    hold_idx = N_ADDR * (1 + BEATS) + DEPTH / BEATS + 1 + DEPTH;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_equal(0, loop_eof, 1'b0, "loop_eof while host writes are open");
    check_equal(4, {reply_eof, led_done, led_error}, 3'b000, "status lights after reset");
    @(posedge clk);
    idx = 0;
    while (idx < msgs.size()) begin
      wr_en   <= 1'b1;
      wr_data <= msgs[idx];
      @(posedge clk);
      if (wr_full) begin
        if (idx >= hold_idx) begin
          saw_full = 1'b1;
          reply_go = 1'b1;
        end
      end else begin
        idx++;
      end
    end
    wr_en        <= 1'b0;
    host_wr_open <= 1'b0;
    reply_go = 1'b1;
    while (loop_idx < exp_loop.size() || rep_idx < exp_reply.size()) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);
    @(negedge clk);
    check_equal(0, loop_eof, 1'b1, "loop_eof after drain");
    check_equal(2, saw_full, 1'b1, "wr_full under reply back-pressure");
    check_equal(3, led_error, 1'b1, "sticky error light");
    check_equal(4, req_count, exp_reqs, "memory requests");
    check_equal(4, {reply_eof, led_done}, 2'b11, "end of stream flags");
    check_equal(5, hb_toggles >= 2, 1'b1, "heartbeat toggling");
    total = host_bridge_top_i.u_cmd_engine.u_engine_assert.fails;
    for (t = 0; t < 6; t++) begin
      $display("test %0d %s: %0d errors", t + 1, names[t], errs[t]);
      total += errs[t];
    end
    $display("summary: 6 tests, %0d assertion failures, %0d errors in all",
             host_bridge_top_i.u_cmd_engine.u_engine_assert.fails, total);
    if (total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/host_bridge_assert.sv
`timescale 1ns/100ps
`default_nettype none

module host_bridge_assert #(
  parameter int FIFO_DEPTH = 16
) (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            mem_valid,
  input logic                            mem_ready,
  input bridge_pkg::mem_req_t            mem_req,
  input logic                            mem_rd_valid,
  input bridge_pkg::engine_state_e       state,
  input logic                            reply_wr_en,
  input logic [$clog2(FIFO_DEPTH+1)-1:0] reply_room
);

  import bridge_pkg::*;

  int fails = 0;

  // Request held steady until the memory takes it
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
    else begin
      $error("mem_req changed or dropped before its transfer");
      fails++;
    end

  // Read data only while a read is outstanding
  rd_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rd_valid |-> state == st_read_wait)
    else begin
      $error("mem_rd_valid outside the read wait state");
      fails++;
    end

  // Reply room stays in range, no push while full
  queue_flags: assert property (@(posedge clk) disable iff (!rst_n)
    reply_room <= FIFO_DEPTH && !(reply_wr_en && reply_room == 0))
    else begin
      $error("reply queue room out of range or pushed while full");
      fails++;
    end

endmodule

bind cmd_engine host_bridge_assert #(.FIFO_DEPTH(FIFO_DEPTH)) u_engine_assert (
  .clk(clk), .rst_n(rst_n), .mem_valid(mem_valid), .mem_ready(mem_ready),
  .mem_req(mem_req), .mem_rd_valid(mem_rd_valid), .state(state),
  .reply_wr_en(reply_wr_en), .reply_room(reply_room)
);

`default_nettype wire

//--- verilog/host_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module host_bridge_top #(
  parameter int MEM_DATA_WIDTH   = 64,
  parameter int FIFO_DEPTH       = 16,
  parameter int HEARTBEAT_CYCLES = 1 << 24
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wr_en,
  input  bridge_pkg::msg_t          wr_data,
  output logic                      wr_full,
  input  logic                      host_wr_open,
  input  logic                      reply_rden,
  output bridge_pkg::msg_t          reply_data,
  output logic                      reply_empty,
  output logic                      reply_eof,
  input  logic                      loop_rden,
  output bridge_pkg::msg_t          loop_data,
  output logic                      loop_empty,
  output logic                      loop_eof,
  output logic                      mem_valid,
  output bridge_pkg::mem_req_t      mem_req,
  input  logic                      mem_ready,
  input  logic                      mem_rd_valid,
  input  logic [MEM_DATA_WIDTH-1:0] mem_rd_data,
  output logic                      led_heartbeat,
  output logic                      led_error,
  output logic                      led_done
);

  import bridge_pkg::*;

  msg_t                              in_data;
  logic                              in_empty;
  logic                              loop_full;
  logic                              msg_take;
  logic                              msg_ack;
  logic                              reply_wr_en;
  msg_t                              reply_wr_data;
  logic [$clog2(FIFO_DEPTH+1)-1:0]   reply_room;
  logic                              end_seen;
  logic                              idle;
  logic                              cmd_error;

  // Pop inbound and push loopback together
  // Loopback back-pressure stalls the engine too
  assign msg_ack = msg_take && !in_empty && !loop_full;

  // ****************************************
  // Host queues
  // ****************************************
  msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .DATA_WIDTH(MSG_WIDTH)) u_inbound_fifo (
    .clk(clk), .rst_n(rst_n),
    .wr_en(wr_en), .wr_data(wr_data), .full(wr_full),
    .rd_en(msg_ack), .rd_data(in_data), .empty(in_empty), .room()
  );

  msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .DATA_WIDTH(MSG_WIDTH)) u_loop_fifo (
    .clk(clk), .rst_n(rst_n),
    .wr_en(msg_ack), .wr_data(in_data), .full(loop_full),
    .rd_en(loop_rden), .rd_data(loop_data), .empty(loop_empty), .room()
  );

  msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .DATA_WIDTH(MSG_WIDTH)) u_reply_fifo (
    .clk(clk), .rst_n(rst_n),
    .wr_en(reply_wr_en), .wr_data(reply_wr_data), .full(),
    .rd_en(reply_rden), .rd_data(reply_data), .empty(reply_empty), .room(reply_room)
  );

  // ****************************************
  // Command engine and status
  // ****************************************
  cmd_engine #(.MEM_DATA_WIDTH(MEM_DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_cmd_engine (
    .clk(clk), .rst_n(rst_n),
    .msg_word(in_data), .msg_present(!in_empty), .msg_take(msg_take), .msg_ack(msg_ack),
    .mem_valid(mem_valid), .mem_req(mem_req), .mem_ready(mem_ready),
    .mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data),
    .reply_wr_en(reply_wr_en), .reply_wr_data(reply_wr_data), .reply_room(reply_room),
    .end_seen(end_seen), .idle(idle), .cmd_error(cmd_error)
  );

  stream_status #(.HEARTBEAT_CYCLES(HEARTBEAT_CYCLES)) u_stream_status (
    .clk(clk), .rst_n(rst_n),
    .end_seen(end_seen), .idle(idle), .cmd_error(cmd_error),
    .reply_empty(reply_empty), .loop_empty(loop_empty), .host_wr_open(host_wr_open),
    .reply_eof(reply_eof), .loop_eof(loop_eof),
    .led_heartbeat(led_heartbeat), .led_error(led_error), .led_done(led_done)
  );

endmodule

`default_nettype wire

//--- verilog/stream_status.sv
`timescale 1ns/100ps
`default_nettype none

module stream_status #(
  parameter int HEARTBEAT_CYCLES = 1 << 24
) (
  input  logic clk,
  input  logic rst_n,
  input  logic end_seen,
  input  logic idle,
  input  logic cmd_error,
  input  logic reply_empty,
  input  logic loop_empty,
  input  logic host_wr_open,
  output logic reply_eof,
  output logic loop_eof,
  output logic led_heartbeat,
  output logic led_error,
  output logic led_done
);

  localparam int HB_WIDTH = $clog2(HEARTBEAT_CYCLES+1);

  logic [HB_WIDTH-1:0] hb_cnt;

  // Reply stream ends once the engine is drained
  assign reply_eof = end_seen && idle && reply_empty;
  assign loop_eof  = !host_wr_open && loop_empty;
  assign led_done  = reply_eof;

  // ****************************************
  // Heartbeat and sticky error
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hb_cnt        <= '0;
      led_heartbeat <= 1'b0;
      led_error     <= 1'b0;
    end else begin
      if (hb_cnt == HB_WIDTH'(HEARTBEAT_CYCLES-1)) begin
        hb_cnt        <= '0;
        led_heartbeat <= !led_heartbeat;
      end else begin
        hb_cnt <= hb_cnt + 1'b1;
      end
      if (cmd_error) begin
        led_error <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- cmd_engine/cmd_engine.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_engine #(
  parameter int MEM_DATA_WIDTH = 64,
  parameter int FIFO_DEPTH     = 16
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  bridge_pkg::msg_t                 msg_word,
  input  logic                             msg_present,
  output logic                             msg_take,
  input  logic                             msg_ack,
  output logic                             mem_valid,
  output bridge_pkg::mem_req_t             mem_req,
  input  logic                             mem_ready,
  input  logic                             mem_rd_valid,
  input  logic [MEM_DATA_WIDTH-1:0]        mem_rd_data,
  output logic                             reply_wr_en,
  output bridge_pkg::msg_t                 reply_wr_data,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0]  reply_room,
  output logic                             end_seen,
  output logic                             idle,
  output logic                             cmd_error
);

  import bridge_pkg::*;

  // Message words per memory word
  localparam int BEATS      = MEM_DATA_WIDTH / MSG_WIDTH;
  localparam int BEAT_WIDTH = $clog2(BEATS+1);
  localparam int ROOM_WIDTH = $clog2(FIFO_DEPTH+1);

  engine_state_e             state;
  mem_req_t                  req;
  logic [BEAT_WIDTH-1:0]     beat_cnt;
  logic [BEAT_WIDTH-1:0]     shift_cnt;
  logic [MEM_DATA_WIDTH-1:0] rd_buf;
  logic                      end_q;
  logic                      error_q;
  logic                      consume;
  logic                      is_end;
  logic                      room_ok;
  msg_op_e                   word_op;

  assign consume = msg_ack && msg_present;
  assign is_end  = (msg_word == '1);
  assign word_op = msg_op_e'(msg_word[MSG_WIDTH-1 -: OP_WIDTH]);

  // Reads wait until the reply queue can take every beat
  assign room_ok = (reply_room >= ROOM_WIDTH'(BEATS));

  assign msg_take  = (state == st_fetch) || (state == st_collect);
  assign mem_valid = (state == st_issue) && (!req.is_read || room_ok);
  assign mem_req   = req;

  // Low word of the read buffer goes out first
  assign reply_wr_en   = (shift_cnt != '0);
  assign reply_wr_data = rd_buf[MSG_WIDTH-1:0];

  assign idle      = (state == st_fetch) || (state == st_ended);
  assign end_seen  = end_q;
  assign cmd_error = error_q;

  // ****************************************
  // Control FSM
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_fetch;
      beat_cnt  <= '0;
      shift_cnt <= '0;
      end_q     <= 1'b0;
      error_q   <= 1'b0;
    end else begin
      error_q <= 1'b0;
      case (state)
        st_fetch: begin
          if (consume) begin
            if (is_end) begin
              end_q <= 1'b1;
              state <= st_ended;
            end else if (word_op == op_write) begin
              beat_cnt <= '0;
              state    <= st_collect;
            end else if (word_op == op_read) begin
              state <= st_issue;
            end else begin
              // Unknown opcode, word is dropped
              error_q <= 1'b1;
            end
          end
        end
        st_collect: begin
          if (consume) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == BEAT_WIDTH'(BEATS-1)) begin
              state <= st_issue;
            end
          end
        end
        st_issue: begin
          if (mem_valid && mem_ready) begin
            state <= req.is_read ? st_read_wait : st_fetch;
          end
        end
        st_read_wait: begin
          if (mem_rd_valid) begin
            shift_cnt <= BEAT_WIDTH'(BEATS);
          end else if (shift_cnt != '0) begin
            shift_cnt <= shift_cnt - 1'b1;
            if (shift_cnt == BEAT_WIDTH'(1)) begin
              state <= st_fetch;
            end
          end
        end
        default: begin
          // Stream finished, later words stay queued
          state <= st_ended;
        end
      endcase
    end
  end

  // ****************************************
  // Request and read data payload
  // ****************************************
  always_ff @(posedge clk) begin
    if (state == st_fetch && consume) begin
      req.is_read <= (word_op == op_read);
      req.addr    <= msg_word[ADDR_WIDTH-1:0];
      req.wdata   <= '0;
    end else if (state == st_collect && consume) begin
      req.wdata[beat_cnt*MSG_WIDTH +: MSG_WIDTH] <= msg_word;
    end
    if (state == st_read_wait && mem_rd_valid) begin
      rd_buf <= mem_rd_data;
    end else if (shift_cnt != '0) begin
      rd_buf <= rd_buf >> MSG_WIDTH;
    end
  end

endmodule

`default_nettype wire

//--- verilog/msg_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module msg_fifo #(
  parameter int FIFO_DEPTH = 16,
  parameter int DATA_WIDTH = bridge_pkg::MSG_WIDTH
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wr_en,
  input  logic [DATA_WIDTH-1:0]              wr_data,
  output logic                               full,
  input  logic                               rd_en,
  output logic [DATA_WIDTH-1:0]              rd_data,
  output logic                               empty,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]    room
);

  localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(FIFO_DEPTH+1);

  logic [DATA_WIDTH-1:0] store [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [CNT_WIDTH-1:0]  count;
  logic                  do_write;
  logic                  do_read;

  // Writes while full and reads while empty are dropped
  assign do_write = wr_en && !full;
  assign do_read  = rd_en && !empty;

  assign full  = (count == CNT_WIDTH'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign room  = CNT_WIDTH'(FIFO_DEPTH) - count;

  // Head word falls through to the read side
  assign rd_data = store[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_write) begin
      store[wr_ptr] <= wr_data;
    end
  end

  // ****************************************
  // Pointers and occupancy
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_write && !do_read) begin
        count <= count + 1'b1;
      end else if (do_read && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- common/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

  // ****************************************
  // Message and memory widths
  // ****************************************
  localparam int MSG_WIDTH    = 32;
  localparam int OP_WIDTH     = 4;
  localparam int ADDR_WIDTH   = 27;
  localparam int MEM_DATA_MAX = 64;

  // One host message word
  typedef logic [MSG_WIDTH-1:0] msg_t;

  // Opcode in the top bits of a command word
  // op_end only counts when the whole word is ones
  typedef enum logic [OP_WIDTH-1:0] {
    op_write = 4'h1,
    op_read  = 4'h2,
    op_end   = 4'hf
  } msg_op_e;

  // Command engine states
  typedef enum logic [2:0] {
    st_fetch,
    st_collect,
    st_issue,
    st_read_wait,
    st_ended
  } engine_state_e;

  // ****************************************
  // Memory request, write data rides along
  // ****************************************
  typedef struct packed {
    logic                    is_read;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [MEM_DATA_MAX-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire
